//--- verilog/mmio_cfg.svh
`ifndef MMIO_CFG_SVH
`define MMIO_CFG_SVH

// address map in cpu word addresses
// instruction space is everything at or below REG_LO
`define MMIO_REG_LO 32'd1024

// capture registers sit above REG_LO up to REG_HI inclusive
`define MMIO_REG_HI 32'd1056

// data memory window, above REG_HI up to MEM_HI inclusive
`define MMIO_MEM_HI 32'd1792

// tft write port, above MEM_HI and strictly below TFT_HI
`define MMIO_TFT_HI 32'd2048

// upper byte the wishbone side decodes as memory
`define MMIO_MEM_TAG 8'h33

// capture channels, picked by the bits just above the history index
`define MMIO_N_CHAN 4 // 2 also works

// history words kept per channel
// N_CHAN * HIST spans the 5-bit register address
`define MMIO_HIST 8

// stand-in memory
`define MMIO_MEM_WAIT 2 // busy cycles per access, at least 1
`define MMIO_MEM_DEPTH 1024 // words, indexed by the low address bits

`endif

//--- verilog/mmio_pkg.sv
package mmio_pkg;

    // request code from the cpu memory handler
    // encoding matches the 2-bit rwi bus of the handler
    typedef enum logic [1:0] {
        op_idle  = 2'b00, // nothing this cycle
        op_write = 2'b01, // store from the cpu
        op_read  = 2'b10, // load into the cpu
        op_fetch = 2'b11  // instruction fetch
    } mem_op_e;

    // address window a request falls into
    typedef enum logic [1:0] {
        reg_instr = 2'b00, // at or below REG_LO, instruction memory
        reg_ext   = 2'b01, // capture register bank
        reg_data  = 2'b10, // data memory through wishbone
        reg_tft   = 2'b11  // spi tft write port, anything above MEM_HI
    } region_e;

endpackage

//--- verilog/chan_if.sv
`timescale 1ns/1ps

`include "mmio_cfg.svh"

// one capture channel as seen from the router side
interface chan_if;

    logic                          rd;      // single read strobe
    logic [$clog2(`MMIO_HIST)-1:0] reg_idx; // history slot to read
    logic [31:0]                   rdata;   // registered read word
    logic                          ack;     // one cycle after rd
    logic                          valid;   // channel holds at least one sample

    // router issues the read
    modport router (
        output rd,
        output reg_idx
    );

    // channel answers it
    modport channel (
        input  rd,
        input  reg_idx,
        output rdata,
        output ack,
        output valid
    );

    // merge only observes
    modport merge (
        input rd,
        input reg_idx,
        input rdata,
        input ack,
        input valid
    );

endinterface

//--- verilog/mmio_router.sv
`timescale 1ns/1ps

`include "mmio_cfg.svh"

module mmio_router import mmio_pkg::*; (
    // cpu memory handler side
    input  mem_op_e                 rwi,
    input  logic [31:0]             addr_in,
    input  logic [31:0]             mem_data,          // store data from the cpu
    input  logic                    addr_control_in,
    // wishbone memory side
    input  logic [31:0]             mem_rdata,
    input  logic                    mem_busy,
    // tft side
    input  logic                    tft_ack,
    // capture channels
    chan_if.router                  chan [`MMIO_N_CHAN],
    input  logic [31:0]             merge_rdata,
    input  logic                    merge_ack,
    input  logic [`MMIO_N_CHAN-1:0] merge_valid,       // per channel chip select
    // outputs
    output logic                    busy,              // stalls the cpu
    output logic                    read,
    output logic                    write,
    output logic [31:0]             addr_out,
    output logic [31:0]             write_data,
    output logic [31:0]             ext_data,          // load result to the cpu
    output logic [31:0]             write_instruction, // fetched word
    output logic                    tft_wr,
    output logic [31:0]             tft_addr,
    output logic [31:0]             tft_wdata,
    output logic                    addr_control_out
);

    localparam int IDX_W = $clog2(`MMIO_HIST);
    localparam int SEL_W = $clog2(`MMIO_N_CHAN);

    region_e          region;
    logic [SEL_W-1:0] chan_sel;
    logic [31:0]      tagged_addr;
    logic             ext_rd_req; // load aimed at the register bank
    logic             cs;         // selected channel has data
    logic             reg_rd;

    // window compare, bounds are word addresses
    function automatic region_e addr_region(input logic [31:0] a);
        if (a <= `MMIO_REG_LO)
            return reg_instr;
        else if (a <= `MMIO_REG_HI)
            return reg_ext;
        else if (a <= `MMIO_MEM_HI)
            return reg_data;
        else
            return reg_tft;
    endfunction

    assign region      = addr_region(addr_in);
    assign chan_sel    = addr_in[IDX_W +: SEL_W]; // bits above the slot index
    assign tagged_addr = {`MMIO_MEM_TAG, addr_in[23:0]};
    assign ext_rd_req  = (region == reg_ext) && (rwi == op_read);
    assign cs          = merge_valid[chan_sel];
    assign reg_rd      = ext_rd_req && cs;

    // one-hot read strobe, idx only on the selected channel
    for (genvar i = 0; i < `MMIO_N_CHAN; i++) begin : g_chan_drv
        assign chan[i].rd      = reg_rd && (chan_sel == i);
        assign chan[i].reg_idx = (reg_rd && chan_sel == i) ? addr_in[IDX_W-1:0] : '0;
    end

    always_comb begin
        busy              = 1'b0;
        read              = 1'b0;
        write             = 1'b0;
        addr_out          = '0;
        write_data        = '0;
        ext_data          = '0;
        write_instruction = '0;
        tft_wr            = 1'b0;
        tft_addr          = '0;
        tft_wdata         = '0;
        addr_control_out  = addr_control_in; // pc / data address mux select

        // wishbone strobes follow the op code only
        case (rwi)
            op_fetch, op_read: read  = 1'b1;
            op_write:          write = 1'b1;
            default:           ;
        endcase

        // stall priority: external busy, then register ack wait, then no data yet
        if (tft_ack || mem_busy)
            busy = 1'b1;
        else if (ext_rd_req)
            busy = cs ? ~merge_ack : 1'b1; // ack lands one cycle after rd

        if (rwi != op_idle) begin
            if (rwi == op_fetch || region == reg_instr) begin
                addr_out          = tagged_addr; // instruction path
                write_instruction = mem_rdata;
            end else begin
                case (region)
                    reg_data: begin
                        addr_out = tagged_addr;
                        if (rwi == op_read)
                            ext_data = mem_rdata;
                        else
                            write_data = mem_data;
                    end
                    reg_tft: begin
                        // write only, reads here return nothing
                        if (rwi == op_write && addr_in < `MMIO_TFT_HI) begin
                            tft_wr    = 1'b1;
                            tft_addr  = addr_in;
                            tft_wdata = mem_data;
                        end
                    end
                    reg_ext: begin
                        if (reg_rd)
                            ext_data = merge_rdata; // zero until ack
                    end
                    default: ;
                endcase
            end
        end
    end

endmodule

//--- verilog/ext_reg_channel.sv
`timescale 1ns/1ps

`include "mmio_cfg.svh"

module ext_reg_channel (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        sample,      // capture strobe from the outside world
    input  logic [31:0] sample_data,
    chan_if.channel     ch
);

    logic [31:0] hist [`MMIO_HIST]; // slot 0 newest
    logic [31:0] rdata_q;
    logic        valid_q;
    logic        ack_q;
    logic        rd_take;

    // rd stays up during the ack cycle, so skip it there
    // a back to back read then gets its own ack
    assign rd_take = ch.rd & ~ack_q;

    // history shift register
    // cleared so slots not yet filled read back as zero
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `MMIO_HIST; i++) begin
                hist[i] <= '0;
            end
        end else if (sample) begin
            hist[0] <= sample_data;
            for (int i = 1; i < `MMIO_HIST; i++) begin
                hist[i] <= hist[i-1]; // older samples move up
            end
        end
    end

    // read word, sampled together with the ack
    always_ff @(posedge clk) begin
        if (rd_take)
            rdata_q <= hist[ch.reg_idx]; // pre-shift value on a same cycle sample
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
            ack_q   <= 1'b0;
        end else begin
            if (sample)
                valid_q <= 1'b1; // sticky after the first capture
            ack_q <= rd_take;
        end
    end

    assign ch.rdata = rdata_q;
    assign ch.ack   = ack_q;
    assign ch.valid = valid_q;

endmodule

//--- verilog/ext_reg_merge.sv
`timescale 1ns/1ps

`include "mmio_cfg.svh"

module ext_reg_merge (
    chan_if.merge                   chan [`MMIO_N_CHAN],
    output logic [31:0]             merge_rdata,
    output logic                    merge_ack,
    output logic [`MMIO_N_CHAN-1:0] merge_valid
);

    logic [`MMIO_N_CHAN-1:0] ack_v;
    logic [31:0]             rdata_v [`MMIO_N_CHAN];

    // flatten the interface array into plain vectors
    for (genvar i = 0; i < `MMIO_N_CHAN; i++) begin : g_gather
        assign ack_v[i]       = chan[i].ack;
        assign rdata_v[i]     = chan[i].rdata;
        assign merge_valid[i] = chan[i].valid; // chip select per channel
    end

    assign merge_ack = |ack_v;

    // and-or mux, router only ever reads one channel at a time
    always_comb begin
        merge_rdata = '0;
        for (int i = 0; i < `MMIO_N_CHAN; i++) begin
            if (ack_v[i])
                merge_rdata = merge_rdata | rdata_v[i];
        end
    end

endmodule

//--- verilog/data_mem.sv
`timescale 1ns/1ps

`include "mmio_cfg.svh"

module data_mem (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        read,
    input  logic        write,
    input  logic [31:0] addr,     // tagged address from the router
    input  logic [31:0] wdata,
    output logic [31:0] rdata,
    output logic        mem_busy
);

    localparam int AW = $clog2(`MMIO_MEM_DEPTH);
    localparam int CW = $clog2(`MMIO_MEM_WAIT + 1);

    logic [31:0]   mem [`MMIO_MEM_DEPTH];
    logic [CW-1:0] wait_cnt;
    logic [31:0]   addr_q;  // request held for the final cycle
    logic [31:0]   wdata_q;
    logic          wr_q;
    logic          req_q;   // tagged request seen last cycle
    logic          req;
    logic          same_req;
    logic          start;

    // untagged accesses belong to someone else, no wait states for them
    assign req      = (read | write) && (addr[31:24] == `MMIO_MEM_TAG);
    assign same_req = (addr == addr_q) && (write == wr_q) && (!write || wdata == wdata_q);
    // a held request after completion must not start again
    assign start    = req && !mem_busy && !(req_q && same_req);
    assign mem_busy = |wait_cnt;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wait_cnt <= '0;
            req_q    <= 1'b0;
        end else begin
            req_q <= req;
            if (start)
                wait_cnt <= CW'(`MMIO_MEM_WAIT);
            else if (mem_busy)
                wait_cnt <= wait_cnt - 1'b1; // busy drops as it hits zero
        end
    end

    // latch the request when the wait starts
    always_ff @(posedge clk) begin
        if (start) begin
            addr_q  <= addr;
            wdata_q <= wdata;
            wr_q    <= write;
        end
    end

    // array access on the last wait cycle
    always_ff @(posedge clk) begin
        if (wait_cnt == CW'(1)) begin
            if (wr_q)
                mem[addr_q[AW-1:0]] <= wdata_q;
            else
                rdata <= mem[addr_q[AW-1:0]]; // held until the next read
        end
    end

endmodule

//--- verilog/mmio_top.sv
`timescale 1ns/1ps

`include "mmio_cfg.svh"

module mmio_top import mmio_pkg::*; (
    input  logic                          clk,
    input  logic                          rst_n,
    // cpu memory handler
    input  mem_op_e                       rwi,
    input  logic [31:0]                   addr_in,
    input  logic [31:0]                   mem_data,
    input  logic                          addr_control_in,
    // capture inputs, one strobe and word per channel
    input  logic [`MMIO_N_CHAN-1:0]       sample,
    input  logic [`MMIO_N_CHAN-1:0][31:0] sample_data,
    // tft controller
    input  logic                          tft_ack,
    output logic                          busy,
    output logic [31:0]                   ext_data,
    output logic [31:0]                   write_instruction,
    output logic                          tft_wr,
    output logic [31:0]                   tft_addr,
    output logic [31:0]                   tft_wdata,
    output logic                          addr_control_out
);

    logic                    read;
    logic                    write;
    logic [31:0]             addr_out;
    logic [31:0]             write_data;
    logic [31:0]             mem_rdata;
    logic                    mem_busy;
    logic [31:0]             merge_rdata;
    logic                    merge_ack;
    logic [`MMIO_N_CHAN-1:0] merge_valid;

    chan_if chan_bus [`MMIO_N_CHAN] (); // router -> channels -> merge

    // all routing is combinational in here
    mmio_router router_inst (
        .rwi               (rwi),
        .addr_in           (addr_in),
        .mem_data          (mem_data),
        .addr_control_in   (addr_control_in),
        .mem_rdata         (mem_rdata),
        .mem_busy          (mem_busy),
        .tft_ack           (tft_ack),
        .chan              (chan_bus),
        .merge_rdata       (merge_rdata),
        .merge_ack         (merge_ack),
        .merge_valid       (merge_valid),
        .busy              (busy),
        .read              (read),
        .write             (write),
        .addr_out          (addr_out),
        .write_data        (write_data),
        .ext_data          (ext_data),
        .write_instruction (write_instruction),
        .tft_wr            (tft_wr),
        .tft_addr          (tft_addr),
        .tft_wdata         (tft_wdata),
        .addr_control_out  (addr_control_out)
    );

    for (genvar i = 0; i < `MMIO_N_CHAN; i++) begin : g_chan
        ext_reg_channel chan_inst (
            .clk         (clk),
            .rst_n       (rst_n),
            .sample      (sample[i]),
            .sample_data (sample_data[i]),
            .ch          (chan_bus[i])
        );
    end

    ext_reg_merge merge_inst (
        .chan        (chan_bus),
        .merge_rdata (merge_rdata),
        .merge_ack   (merge_ack),
        .merge_valid (merge_valid)
    );

    // stands in for the wishbone manager plus memory
    data_mem mem_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .read     (read),
        .write    (write),
        .addr     (addr_out),
        .wdata    (write_data),
        .rdata    (mem_rdata),
        .mem_busy (mem_busy)
    );

endmodule

//--- bench/mmio_sva.sv
`timescale 1ns/1ps

`include "mmio_cfg.svh"

module mmio_sva import mmio_pkg::*; (
    input logic        clk,
    input logic        rst_n,
    input mem_op_e     rwi,
    input logic [31:0] addr_in,
    input logic [31:0] mem_data,
    input logic        tft_ack,
    input logic        busy,
    input logic        read,
    input logic        write,
    input logic [31:0] addr_out,
    input logic        tft_wr,
    input logic [31:0] tft_addr,
    input logic [31:0] tft_wdata,
    input logic        mem_busy,
    input logic        merge_ack
);

    int   fail_count = 0; // watched from the testbench
    logic mem_path;       // request belongs on the wishbone memory side

    task automatic flag_error(input string why);
        $error("%s", why);
        fail_count++;
    endtask

    // fetches, the instruction window and the data window go to memory
    assign mem_path = (rwi == op_fetch)
                   || (rwi != op_idle && addr_in <= `MMIO_REG_LO)
                   || (rwi != op_idle && addr_in > `MMIO_REG_HI && addr_in <= `MMIO_MEM_HI);

    // sync reset clears every stall source
    a_reset_quiet: assert property (@(posedge clk) !rst_n |=> !mem_busy && !merge_ack)
        else flag_error("stall source still set one cycle into reset");

    a_tft_stall: assert property (@(posedge clk) disable iff (!rst_n) tft_ack |-> busy)
        else flag_error("busy low while tft_ack is high");

    // strobes follow the op code, nothing else
    a_strobe_op: assert property (@(posedge clk) disable iff (!rst_n)
        read == (rwi == op_read || rwi == op_fetch) && write == (rwi == op_write))
        else flag_error("read or write strobe does not match rwi");

    a_mem_tag: assert property (@(posedge clk) disable iff (!rst_n)
        addr_out == (mem_path ? {`MMIO_MEM_TAG, addr_in[23:0]} : 32'h0))
        else flag_error("addr_out does not follow the memory routing rule");

    // tft strobe only for writes inside the tft window
    a_tft_path: assert property (@(posedge clk) disable iff (!rst_n)
        tft_wr == (rwi == op_write && addr_in > `MMIO_MEM_HI && addr_in < `MMIO_TFT_HI)
        && (!tft_wr || (tft_addr == addr_in && tft_wdata == mem_data)))
        else flag_error("tft write strobe, address or data does not match the request");

    // fixed wait length, then at least one free cycle
    a_mem_wait: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(mem_busy) |-> mem_busy [*`MMIO_MEM_WAIT] ##1 !mem_busy)
        else flag_error("memory busy length differs from the wait setting");

    a_ack_pulse: assert property (@(posedge clk) disable iff (!rst_n) merge_ack |=> !merge_ack)
        else flag_error("channel ack held for more than one cycle");

endmodule

bind mmio_top mmio_sva sva_inst (.*);

//--- bench/mmio_tb.sv
`timescale 1ns/1ps

`include "mmio_cfg.svh"

module mmio_tb import mmio_pkg::*; ();

    localparam int TIMEOUT = 50; // cycles per busy wait

    logic                          clk;
    logic                          rst_n;
    mem_op_e                       rwi;
    logic [31:0]                   addr_in;
    logic [31:0]                   mem_data;
    logic                          addr_control_in;
    logic [`MMIO_N_CHAN-1:0]       sample;
    logic [`MMIO_N_CHAN-1:0][31:0] sample_data;
    logic                          tft_ack;
    logic                          busy;
    logic [31:0]                   ext_data;
    logic [31:0]                   write_instruction;
    logic                          tft_wr;
    logic [31:0]                   tft_addr;
    logic [31:0]                   tft_wdata;
    logic                          addr_control_out;

    integer      seed;
    logic [31:0] ref_mem [int];               // keyed by the low 10 address bits
    logic [31:0] hist_q [`MMIO_N_CHAN][$];    // newest sample at the front
    logic [31:0] a;
    logic [31:0] d;

    mmio_top mmio_top_inst (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    task automatic check_word(input string test, input logic [31:0] exp,
                              input logic [31:0] act);
        assert (act === exp)
        else abort_run($sformatf("MISMATCH %s expected %h actual %h", test, exp, act));
    endtask

    // a bound assertion firing ends the run too
    always @(negedge clk) begin
        if (mmio_top_inst.sva_inst.fail_count != 0)
            abort_run("a concurrent assertion in mmio_sva failed");
    end

    // new request on the falling edge, look at outputs 1 ns later
    task automatic drive(input mem_op_e op, input logic [31:0] addr, input logic [31:0] data);
        @(negedge clk);
        rwi             = op;
        addr_in         = addr;
        mem_data        = data;
        addr_control_in = $random(seed);
        #1;
        check_word("addr_control passthrough", addr_control_in, addr_control_out);
    endtask

    task automatic wait_busy(input logic level, input string test);
        int n;
        n = 0;
        while (busy !== level && n < TIMEOUT) begin
            @(negedge clk);
            #1;
            n++;
        end
        if (busy !== level)
            abort_run($sformatf("timeout in %s waiting for busy to become %0b", test, level));
    endtask

    task automatic idle_check();
        drive(op_idle, $random(seed), $random(seed));
        check_word("idle busy", 0, busy);
        check_word("idle ext_data", 0, ext_data);
        check_word("idle write_instruction", 0, write_instruction);
        check_word("idle tft_wr", 0, tft_wr);
        check_word("idle tft_addr", 0, tft_addr);
        check_word("idle tft_wdata", 0, tft_wdata);
        check_word("idle addr_out", 0, mmio_top_inst.addr_out);
    endtask

    // memory side: busy rises a cycle late, then falls after the wait states
    task automatic mem_access(input mem_op_e op, input logic [31:0] addr,
                              input logic [31:0] data, input string test);
        drive(op, addr, data);
        check_word({test, " addr_out"}, {`MMIO_MEM_TAG, addr[23:0]}, mmio_top_inst.addr_out);
        wait_busy(1'b1, test);
        wait_busy(1'b0, test);
    endtask

    task automatic capture(input int c, input logic [31:0] w);
        @(negedge clk);
        sample[c]      = 1'b1;
        sample_data[c] = w;
        @(negedge clk);
        sample[c] = 1'b0;
        hist_q[c].push_front(w);
        if (hist_q[c].size() > `MMIO_HIST)
            void'(hist_q[c].pop_back()); // oldest falls off the end
    endtask

    // channel in bits 4:3, slot in 2:0, above REG_LO
    function automatic logic [31:0] reg_addr(input int c, input int idx);
        logic [31:0] r;
        r = `MMIO_REG_LO + c * `MMIO_HIST + idx;
        if (r == `MMIO_REG_LO)
            r = `MMIO_REG_HI; // same low bits, inside the window
        return r;
    endfunction

    task automatic reg_read(input int c, input int idx);
        logic [31:0] exp;
        exp = (idx < hist_q[c].size()) ? hist_q[c][idx] : 32'h0; // unfilled slots read 0
        drive(op_read, reg_addr(c, idx), $random(seed));
        check_word("reg read busy at request", 1, busy);
        @(negedge clk);
        #1;
        check_word("reg read busy one cycle later", 0, busy);
        check_word($sformatf("reg read ch%0d idx%0d", c, idx), exp, ext_data);
        idle_check();
    endtask

    initial begin
        seed            = 32'h7d9b3cad;
        rst_n           = 1'b0;
        rwi             = op_idle;
        addr_in         = '0;
        mem_data        = '0;
        addr_control_in = 1'b0;
        sample          = '0;
        sample_data     = '0;
        tft_ack         = 1'b0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        #1;
        check_word("reset busy", 0, busy);
        check_word("reset tft_wr", 0, tft_wr);

        // channel with no samples stalls indefinitely
        drive(op_read, reg_addr(2, 3), 32'h0);
        repeat (6) begin
            @(negedge clk);
            #1;
            check_word("empty channel busy", 1, busy);
        end
        idle_check();

        // data write, read back, then fetch of the same word from low memory
        for (int i = 0; i < 12; i++) begin
            a = `MMIO_REG_HI + 1 + {$random(seed)} % (`MMIO_MEM_HI - `MMIO_REG_HI);
            d = $random(seed);
            mem_access(op_write, a, d, "data write");
            ref_mem[a[9:0]] = d;
            idle_check();
            mem_access(op_read, a, 32'h0, "data read");
            check_word("data read ext_data", ref_mem[a[9:0]], ext_data);
            check_word("data read write_instruction", 0, write_instruction);
            idle_check();
            mem_access(op_fetch, a - `MMIO_REG_LO, 32'h0, "fetch");
            check_word("fetch write_instruction", ref_mem[a[9:0]], write_instruction);
            check_word("fetch ext_data", 0, ext_data);
            idle_check();
        end

        // tft writes, then ack stalls the cpu
        for (int i = 0; i < 4; i++) begin
            a = `MMIO_MEM_HI + 1 + {$random(seed)} % (`MMIO_TFT_HI - `MMIO_MEM_HI - 1);
            d = $random(seed);
            drive(op_write, a, d);
            check_word("tft tft_wr", 1, tft_wr);
            check_word("tft tft_addr", a, tft_addr);
            check_word("tft tft_wdata", d, tft_wdata);
            @(negedge clk);
            tft_ack = 1'b1;
            #1;
            check_word("tft ack busy", 1, busy);
            @(negedge clk);
            tft_ack = 1'b0;
            idle_check();
        end

        // writes into the register window go nowhere
        for (int i = 0; i < 4; i++) begin
            drive(op_write, reg_addr(i % `MMIO_N_CHAN, i + 1), $random(seed));
            check_word("reg write busy", 0, busy);
            check_word("reg write tft_wr", 0, tft_wr);
            check_word("reg write ext_data", 0, ext_data);
            check_word("reg write addr_out", 0, mmio_top_inst.addr_out);
            idle_check();
        end

        // fill every channel, some past the history depth
        for (int c = 0; c < `MMIO_N_CHAN; c++) begin
            repeat (1 + {$random(seed)} % 11) capture(c, $random(seed));
        end
        for (int i = 0; i < 24; i++) begin
            if ($random(seed) & 1)
                capture({$random(seed)} % `MMIO_N_CHAN, $random(seed));
            reg_read({$random(seed)} % `MMIO_N_CHAN, {$random(seed)} % `MMIO_HIST);
        end

        repeat (2) @(negedge clk);
        if (mmio_top_inst.sva_inst.fail_count != 0) begin
            abort_run("a concurrent assertion in mmio_sva failed");
        end else begin
            $display("ALL CHECKS PASSED");
            $finish;
        end
    end

endmodule

//--- build.f
+incdir+verilog
verilog/mmio_pkg.sv
verilog/chan_if.sv
verilog/mmio_router.sv
verilog/ext_reg_channel.sv
verilog/ext_reg_merge.sv
verilog/data_mem.sv
verilog/mmio_top.sv
bench/mmio_sva.sv
bench/mmio_tb.sv

//--- Bender.yml
package:
  name: mmio_subsystem

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/mmio_pkg.sv
      - verilog/chan_if.sv
      - verilog/mmio_router.sv
      - verilog/ext_reg_channel.sv
      - verilog/ext_reg_merge.sv
      - verilog/data_mem.sv
      - verilog/mmio_top.sv
  - target: simulation
    include_dirs:
      - verilog
    files:
      - bench/mmio_sva.sv
      - bench/mmio_tb.sv
